// ==== hw/shreg_pkg.sv ====
package shreg_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // shift modes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [1:0] {
    mode_siso_r = 2'b00,  // serial in, shift toward bit 0.
    mode_siso_l = 2'b01,  // serial in, shift toward msb.
    mode_piso   = 2'b10,  // right shift, zero fill.
    mode_pipo   = 2'b11   // hold.
  } shift_mode_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // apb register map
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [4:0] {
    addr_ctrl   = 5'h00,  // mode in bits 1:0.
    addr_data   = 5'h04,  // write loads, read gives corrected word.
    addr_status = 5'h08,  // syndrome and sticky fault flag.
    addr_inject = 5'h0C,  // data and parity flip masks.
    addr_count  = 5'h10   // saturating correction count.
  } reg_addr_e;

  // register width unless the top level overrides it.
  parameter int default_width = 16;

endpackage

// ==== hw/ecc_pkg.sv ====
package ecc_pkg;

  parameter int n_parity = 3;

  typedef logic [n_parity-1:0] syndrome_t;

  // bit named by a nonzero syndrome.
  typedef enum logic [2:0] {
    synd_none,
    synd_data0,
    synd_data1,
    synd_data2,
    synd_data3,
    synd_par1,
    synd_par2,
    synd_par3
  } synd_class_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Hamming(7,4) over the low nibble. Bit 0 of the result is p1.
  //   p1 = d0 ^ d2 ^ d3
  //   p2 = d0 ^ d1 ^ d3
  //   p3 = d0 ^ d1 ^ d2
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [n_parity-1:0] hamming_par(input logic [3:0] d);
    hamming_par[0] = d[0] ^ d[2] ^ d[3];
    hamming_par[1] = d[0] ^ d[1] ^ d[3];
    hamming_par[2] = d[0] ^ d[1] ^ d[2];
  endfunction

  function automatic synd_class_e synd_class(input syndrome_t s);
    case (s)
      3'b111:  synd_class = synd_data0;
      3'b110:  synd_class = synd_data1;
      3'b101:  synd_class = synd_data2;
      3'b011:  synd_class = synd_data3;
      3'b001:  synd_class = synd_par1;
      3'b010:  synd_class = synd_par2;
      3'b100:  synd_class = synd_par3;
      default: synd_class = synd_none;
    endcase
  endfunction

endpackage

// ==== hw/shift_core.sv ====
module shift_core
  import shreg_pkg::*;
#(
  parameter int WIDTH = default_width
) (
  input  logic             clk,
  input  logic             rst,
  input  shift_mode_e      mode,
  input  logic             shift_en,
  input  logic             serial_in,
  input  logic             load,
  input  logic [WIDTH-1:0] load_data,
  input  logic             inj,
  input  logic [WIDTH-1:0] inj_data,
  input  logic             wb,
  input  logic [WIDTH-1:0] corr_data,
  output logic [WIDTH-1:0] data_q,
  output logic [WIDTH-1:0] data_next,
  output logic             serial_out
);

  logic [WIDTH-1:0] shift_word;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // next word
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    case (mode)
      mode_siso_r: shift_word = {serial_in, data_q[WIDTH-1:1]};
      mode_siso_l: shift_word = {data_q[WIDTH-2:0], serial_in};
      mode_piso:   shift_word = {1'b0, data_q[WIDTH-1:1]};  // zero fill.
      default:     shift_word = data_q;                     // pipo holds.
    endcase
  end

  // a load beats a shift in the same cycle, parity follows this word.
  assign data_next = load ? load_data : shift_word;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      data_q <= '0;
    end else if (inj) begin
      data_q <= data_q ^ inj_data;  // no parity update.
    end else if (load || shift_en) begin
      data_q <= data_next;
    end else if (wb) begin
      data_q <= corr_data;          // repair on an idle cycle.
    end
  end

  // lsb leaves first in the right shifting modes.
  assign serial_out = (mode == mode_siso_r || mode == mode_piso) ?
                      data_q[0] : data_q[WIDTH-1];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // mode comes from the apb slave and steers both the shift and the parity.
  a_mode_known: assert property (
    @(posedge clk) disable iff (!rst) !$isunknown(mode)
  ) else $error("shift_core: mode is unknown");

endmodule

// ==== hw/hamming_check.sv ====
module hamming_check
  import shreg_pkg::*, ecc_pkg::*;
#(
  parameter int WIDTH = default_width
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [WIDTH-1:0]    data_q,
  input  logic [WIDTH-1:0]    data_next,
  input  logic                load,
  input  logic                shift_en,
  input  logic                inj,
  input  logic [n_parity-1:0] inj_par,
  input  logic                wb,
  input  logic [n_parity-1:0] corr_par,
  output logic [n_parity-1:0] par_q,
  output syndrome_t           syndrome
);

  logic [n_parity-1:0] par_next;
  logic [n_parity-1:0] par_now;

  // parity of the word that the next load or shift stores.
  assign par_next = hamming_par(data_next[3:0]);

  // parity of what is stored right now.
  assign par_now = hamming_par(data_q[3:0]);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // parity storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // same priority as the data register, so both stay in step.
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      par_q <= '0;
    end else if (inj) begin
      par_q <= par_q ^ inj_par;
    end else if (load || shift_en) begin
      par_q <= par_next;
    end else if (wb) begin
      par_q <= corr_par;
    end
  end

  // zero when stored and recomputed parity agree.
  assign syndrome = par_q ^ par_now;

endmodule

// ==== hw/ecc_correct.sv ====
module ecc_correct
  import shreg_pkg::*, ecc_pkg::*;
#(
  parameter int WIDTH = default_width
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [WIDTH-1:0]    data_q,
  input  logic [n_parity-1:0] par_q,
  input  syndrome_t           syndrome,
  input  logic                shift_en,
  input  logic                load,
  input  logic                inj,
  output logic [WIDTH-1:0]    corr_data,
  output logic [n_parity-1:0] corr_par,
  output logic                fault,
  output logic                wb,
  output logic [7:0]          corr_count
);

  synd_class_e synd_cls;

  assign synd_cls = synd_class(syndrome);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // single bit repair
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    corr_data = data_q;
    corr_par  = par_q;
    case (synd_cls)
      synd_data0: corr_data[0] = ~data_q[0];
      synd_data1: corr_data[1] = ~data_q[1];
      synd_data2: corr_data[2] = ~data_q[2];
      synd_data3: corr_data[3] = ~data_q[3];
      synd_par1:  corr_par[0]  = ~par_q[0];
      synd_par2:  corr_par[1]  = ~par_q[1];
      synd_par3:  corr_par[2]  = ~par_q[2];
      default:    ;                          // clean word.
    endcase
  end

  assign fault = (synd_cls != synd_none);

  // storage is busy with a shift, load or inject, repair waits.
  assign wb = fault && !shift_en && !load && !inj;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      corr_count <= '0;
    end else if (wb && corr_count != 8'hff) begin
      corr_count <= corr_count + 8'd1;  // saturates.
    end
  end

  // the repaired word is one flip from storage and a valid codeword.
  a_one_flip: assert property (
    @(posedge clk) disable iff (!rst)
      $countones({corr_data ^ data_q, corr_par ^ par_q}) <= 1 &&
      hamming_par(corr_data[3:0]) == corr_par
  ) else $error("ecc_correct: repair is not a single flip to a codeword");

endmodule

// ==== hw/apb_regs.sv ====
module apb_regs
  import shreg_pkg::*, ecc_pkg::*;
#(
  parameter int WIDTH = default_width
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [4:0]          paddr,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  logic [31:0]         pwdata,
  input  logic                fault,
  input  syndrome_t           syndrome,
  input  logic [WIDTH-1:0]    corr_data,
  input  logic [7:0]          corr_count,
  output logic [31:0]         prdata,
  output logic                pready,
  output logic                pslverr,
  output shift_mode_e         mode,
  output logic                load,
  output logic [WIDTH-1:0]    load_data,
  output logic                inj,
  output logic [WIDTH-1:0]    inj_data,
  output logic [n_parity-1:0] inj_par,
  output logic                clr_fault
);

  logic        access;
  logic        addr_ok;
  logic        ro_write;
  logic        wr_ok;
  logic        fault_flag;
  logic [31:0] inject_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign access = psel && penable;  // zero wait, access phase only.

  always_comb begin
    case (paddr)
      addr_ctrl, addr_data, addr_status, addr_inject, addr_count: addr_ok = 1'b1;
      default: addr_ok = 1'b0;
    endcase
  end

  assign ro_write = pwrite && (paddr == addr_status || paddr == addr_count);
  assign pslverr  = access && (!addr_ok || ro_write);
  assign pready   = 1'b1;
  assign wr_ok    = access && pwrite && !pslverr;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pulses to the storage blocks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign load      = wr_ok && paddr == addr_data;
  assign load_data = pwdata[WIDTH-1:0];
  assign inj       = wr_ok && paddr == addr_inject;
  assign inj_data  = pwdata[WIDTH-1:0];
  assign inj_par   = pwdata[16 +: n_parity];  // parity mask at 18:16.

  // status write still clears the flag although it reports an error.
  assign clr_fault = access && pwrite && paddr == addr_status && pwdata[0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      mode       <= mode_siso_r;
      fault_flag <= 1'b0;
      inject_q   <= '0;
    end else begin
      if (wr_ok && paddr == addr_ctrl) begin
        mode <= shift_mode_e'(pwdata[1:0]);
      end
      if (inj) begin
        inject_q <= pwdata;  // last mask, for readback.
      end
      fault_flag <= (fault_flag && !clr_fault) || fault;  // a live fault wins.
    end
  end

  always_comb begin
    prdata = '0;
    case (paddr)
      addr_ctrl:   prdata[1:0]          = mode;
      addr_data:   prdata[WIDTH-1:0]    = corr_data;  // already repaired.
      addr_status: prdata[n_parity:0]   = {syndrome, fault_flag};
      addr_inject: prdata               = inject_q;
      addr_count:  prdata[7:0]          = corr_count;
      default:     prdata               = '0;
    endcase
  end

  // master side protocol rule.
  a_penable_in_sel: assert property (
    @(posedge clk) disable iff (!rst) penable |-> psel
  ) else $error("apb_regs: penable without psel");

endmodule

// ==== hw/shreg_ecc_top.sv ====
module shreg_ecc_top
  import shreg_pkg::*, ecc_pkg::*;
#(
  parameter int WIDTH = default_width
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  input  logic        shift_en,
  input  logic        serial_in,
  output logic        serial_out
);

  shift_mode_e         mode;
  logic                load;
  logic [WIDTH-1:0]    load_data;
  logic                inj;
  logic [WIDTH-1:0]    inj_data;
  logic [n_parity-1:0] inj_par;
  logic [WIDTH-1:0]    data_q;
  logic [WIDTH-1:0]    data_next;
  logic [n_parity-1:0] par_q;
  syndrome_t           syndrome;
  logic [WIDTH-1:0]    corr_data;
  logic [n_parity-1:0] corr_par;
  logic                fault;
  logic                wb;
  logic [7:0]          corr_count;

  shift_core #(.WIDTH(WIDTH)) i_shift_core (
    .clk, .rst, .mode, .shift_en, .serial_in,
    .load, .load_data, .inj, .inj_data, .wb, .corr_data,
    .data_q, .data_next, .serial_out
  );

  hamming_check #(.WIDTH(WIDTH)) i_hamming_check (
    .clk, .rst, .data_q, .data_next, .load, .shift_en,
    .inj, .inj_par, .wb, .corr_par,
    .par_q, .syndrome
  );

  ecc_correct #(.WIDTH(WIDTH)) i_ecc_correct (
    .clk, .rst, .data_q, .par_q, .syndrome, .shift_en, .load, .inj,
    .corr_data, .corr_par, .fault, .wb, .corr_count
  );

  apb_regs #(.WIDTH(WIDTH)) i_apb_regs (
    .clk, .rst, .paddr, .psel, .penable, .pwrite, .pwdata,
    .fault, .syndrome, .corr_data, .corr_count,
    .prdata, .pready, .pslverr,
    .mode, .load, .load_data, .inj, .inj_data, .inj_par,
    .clr_fault ()  // status clear stays inside the slave.
  );

endmodule

// ==== verif/shreg_ecc_tb.sv ====
module shreg_ecc_tb
  import shreg_pkg::*;
();

  localparam int WIDTH      = default_width;
  localparam int clk_period = 100;

  // cycle budgets per test.
  localparam int budget_map      = 40;
  localparam int budget_parallel = 70;
  localparam int budget_serial   = 80;
  localparam int budget_data     = 120;
  localparam int budget_parity   = 100;
  localparam int budget_upper    = 40;
  localparam int budget_total    = budget_map + budget_parallel + budget_serial +
                                   budget_data + budget_parity + budget_upper;
  localparam int watchdog_cycles = 10 + budget_total * 3 / 2;  // reset included.

  logic             clk;
  logic             rst;
  logic [4:0]       paddr;
  logic             psel;
  logic             penable;
  logic             pwrite;
  logic [31:0]      pwdata;
  logic [31:0]      prdata;
  logic             pready;
  logic             pslverr;
  logic             shift_en;
  logic             serial_in;
  logic             serial_out;

  int               n_checks;
  int               n_errors;
  int               exp_count;
  logic [31:0]      lfsr;
  logic [WIDTH-1:0] model_q;
  shift_mode_e      model_mode;

  shreg_ecc_top #(.WIDTH(WIDTH)) i_dut (
    .clk, .rst, .paddr, .psel, .penable, .pwrite, .pwdata,
    .prdata, .pready, .pslverr, .shift_en, .serial_in, .serial_out
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // random bits and reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic next_bit();
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);  // galois, taps 32 22 2 1.
    return lfsr[0];
  endfunction

  function automatic logic [WIDTH-1:0] rand_word();
    logic [WIDTH-1:0] w;
    for (int i = 0; i < WIDTH; i++) begin
      w[i] = next_bit();
    end
    return w;
  endfunction

  function automatic void model_shift(input logic sin);
    case (model_mode)
      mode_siso_r: model_q = {sin, model_q[WIDTH-1:1]};
      mode_siso_l: model_q = {model_q[WIDTH-2:0], sin};
      mode_piso:   model_q = {1'b0, model_q[WIDTH-1:1]};  // zero fill.
      default:     ;                                       // pipo holds.
    endcase
  endfunction

  function automatic logic serial_expect();
    if (model_mode == mode_siso_r || model_mode == mode_piso) begin
      return model_q[0];
    end
    return model_q[WIDTH-1];
  endfunction

  // syndrome that a single flipped data bit produces.
  function automatic logic [2:0] data_syndrome(input int idx);
    case (idx)
      0:       return 3'b111;
      1:       return 3'b110;
      2:       return 3'b101;
      3:       return 3'b011;
      default: return 3'b000;
    endcase
  endfunction

  function automatic logic [2:0] par_syndrome(input int k);
    case (k)
      0:       return 3'b001;  // p1.
      1:       return 3'b010;  // p2.
      2:       return 3'b100;  // p3.
      default: return 3'b000;
    endcase
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus and serial tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("[FAIL] %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic apb_write(input logic [4:0] addr, input logic [31:0] data,
                           output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    #(clk_period / 4);  // mid access phase.
    err = pslverr;
    check_value("pready on write", pready, 1);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [4:0] addr, output logic [31:0] data,
                          output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    #(clk_period / 4);
    data = prdata;
    err  = pslverr;
    check_value("pready on read", pready, 1);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_expect(input logic [4:0] addr, input logic [31:0] exp,
                             input string what);
    logic [31:0] data;
    logic        err;
    apb_read(addr, data, err);
    check_value({what, " pslverr"}, err, 0);
    check_value(what, data, exp);
  endtask

  task automatic write_expect(input logic [4:0] addr, input logic [31:0] data,
                              input logic exp_err, input string what);
    logic err;
    apb_write(addr, data, err);
    check_value({what, " pslverr"}, err, exp_err);
  endtask

  task automatic set_mode(input shift_mode_e m);
    write_expect(addr_ctrl, {30'b0, m}, 1'b0, "ctrl write");
    model_mode = m;
    read_expect(addr_ctrl, {30'b0, m}, "ctrl readback");
  endtask

  task automatic load_word(input logic [WIDTH-1:0] w);
    write_expect(addr_data, w, 1'b0, "data write");
    model_q = w;
  endtask

  // serial_out is checked before each new bit is driven.
  task automatic shift_bits(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      if (i > 0) begin
        check_value("serial_out", serial_out, serial_expect());
      end
      shift_en  = 1'b1;
      serial_in = next_bit();
      model_shift(serial_in);
    end
    @(negedge clk);
    check_value("serial_out", serial_out, serial_expect());
    shift_en  = 1'b0;
    serial_in = 1'b0;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic reset_and_map();
    logic [31:0] data;
    logic        err;
    read_expect(addr_ctrl, 0, "ctrl after reset");
    read_expect(addr_data, 0, "data after reset");
    read_expect(addr_status, 0, "status after reset");
    read_expect(addr_inject, 0, "inject after reset");
    read_expect(addr_count, 0, "count after reset");
    write_expect(addr_status, 32'h0, 1'b1, "status write");
    write_expect(addr_count, 32'h5, 1'b1, "count write");
    write_expect(5'h14, 32'hffff_ffff, 1'b1, "unmapped write");
    apb_read(5'h1c, data, err);
    check_value("unmapped read pslverr", err, 1);
    read_expect(addr_count, 0, "count after refused write");
  endtask

  task automatic parallel_modes();
    logic [WIDTH-1:0] w;
    set_mode(mode_pipo);
    repeat (4) begin
      w = rand_word();
      load_word(w);
      read_expect(addr_data, w, "pipo readback");
    end
    shift_bits(3);
    read_expect(addr_data, model_q, "pipo after shift_en");
    set_mode(mode_piso);
    load_word(rand_word());
    shift_bits(6);
    read_expect(addr_data, model_q, "piso after shift");
  endtask

  task automatic serial_modes();
    set_mode(mode_siso_r);
    load_word(rand_word());
    shift_bits(WIDTH + 3);
    read_expect(addr_data, model_q, "siso_r after shift");
    set_mode(mode_siso_l);
    load_word(rand_word());
    shift_bits(WIDTH + 3);
    read_expect(addr_data, model_q, "siso_l after shift");
  endtask

  // the syndrome is only live for one cycle before the repair.
  task automatic data_repair();
    logic [31:0] mask;
    set_mode(mode_pipo);
    for (int b = 0; b < 4; b++) begin
      load_word(rand_word());
      mask = 32'h1 << b;
      write_expect(addr_inject, mask, 1'b0, "inject data bit");
      check_value("live syndrome", i_dut.syndrome, data_syndrome(b));
      exp_count++;
      read_expect(addr_data, model_q, "data after repair");
      read_expect(addr_status, 32'h1, "status after repair");
      read_expect(addr_count, exp_count, "count after repair");
      read_expect(addr_inject, mask, "inject readback");
      write_expect(addr_status, 32'h1, 1'b1, "status clear");
      read_expect(addr_status, 32'h0, "status after clear");
    end
  endtask

  task automatic parity_repair();
    set_mode(mode_siso_r);
    load_word(rand_word());
    for (int k = 0; k < 3; k++) begin
      write_expect(addr_inject, 32'h1 << (16 + k), 1'b0, "inject parity bit");
      check_value("live syndrome", i_dut.syndrome, par_syndrome(k));
      exp_count++;
      read_expect(addr_data, model_q, "data after parity repair");
      read_expect(addr_status, 32'h1, "status after parity repair");
      read_expect(addr_count, exp_count, "count after parity repair");
      write_expect(addr_status, 32'h1, 1'b1, "status clear");
      shift_bits(3);
      read_expect(addr_status, 32'h0, "status after shift");
      read_expect(addr_count, exp_count, "count after shift");
      read_expect(addr_data, model_q, "data after shift");
    end
  endtask

  task automatic upper_bits();
    logic [3:0] pick;
    int         pos;
    repeat (2) begin
      for (int i = 0; i < 4; i++) begin
        pick = {pick[2:0], next_bit()};
      end
      pos = 4 + int'(pick) % (WIDTH - 4);
      write_expect(addr_inject, 32'h1 << pos, 1'b0, "inject upper bit");
      check_value("live syndrome", i_dut.syndrome, 0);
      model_q[pos] = ~model_q[pos];  // outside the code, stays flipped.
      read_expect(addr_data, model_q, "data after upper flip");
      read_expect(addr_status, 32'h0, "status after upper flip");
      read_expect(addr_count, exp_count, "count after upper flip");
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sequence and watchdog
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    rst        = 1'b0;
    paddr      = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = '0;
    shift_en   = 1'b0;
    serial_in  = 1'b0;
    lfsr       = 32'haa2211c6;
    n_checks   = 0;
    n_errors   = 0;
    exp_count  = 0;
    model_q    = '0;
    model_mode = mode_siso_r;
    repeat (5) @(negedge clk);
    rst = 1'b1;
    reset_and_map();
    parallel_modes();
    serial_modes();
    data_repair();
    parity_repair();
    upper_bits();
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== verilog.f ====
hw/shreg_pkg.sv
hw/ecc_pkg.sv
hw/shift_core.sv
hw/hamming_check.sv
hw/ecc_correct.sv
hw/apb_regs.sv
hw/shreg_ecc_top.sv
verif/shreg_ecc_tb.sv
